/* tb.f */
source/gpu_pkg.sv
source/gpu_regs.sv
source/buffer_clear.sv
source/pixel_plot.sv
source/gpu_engine.sv
source/gpu_core.sv
verif/mem_model.sv
verif/tb_gpu_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pixel engine testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_gpu_core > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_gpu_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* verif/tb_gpu_core.sv */
// tb_gpu_core: testbench for the pixel engine with register, clear and plot command checks
`timescale 1ns/1ns
module tb_gpu_core;

    localparam int          SCREEN_W    = 16;
    localparam int          SCREEN_H    = 8;
    localparam int          NUM_WORDS   = SCREEN_W * SCREEN_H;
    localparam int          CMD_TIMEOUT = 2000;   // done polls per command
    localparam logic [31:0] FRAME_BASE  = 32'h0000_1000;
    localparam logic [31:0] DEPTH_BASE  = 32'h0000_2000;

    logic        CLK;
    logic        RESET;
    logic        chipselect, read, write;
    logic [3:0]  address;
    logic [31:0] writedata, readdata;
    logic [31:0] m_address, m_writedata, m_readdata;
    logic        m_read, m_write, m_waitrequest, m_readdatavalid, m_writeresponsevalid;
    int          write_count, stray_count;
    int          mismatch_errs, timeout_errs, protocol_errs;

    gpu_core #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) i_gpu_core (
        .CLK(CLK), .RESET(RESET),
        .chipselect(chipselect), .read(read), .write(write), .address(address),
        .writedata(writedata), .readdata(readdata),
        .m_address(m_address), .m_read(m_read), .m_write(m_write),
        .m_writedata(m_writedata), .m_waitrequest(m_waitrequest),
        .m_readdata(m_readdata), .m_readdatavalid(m_readdatavalid),
        .m_writeresponsevalid(m_writeresponsevalid)
    );

    mem_model i_mem (
        .CLK(CLK), .RESET(RESET),
        .address(m_address), .read(m_read), .write(m_write), .writedata(m_writedata),
        .waitrequest(m_waitrequest), .readdata(m_readdata),
        .readdatavalid(m_readdatavalid), .writeresponsevalid(m_writeresponsevalid),
        .frame_base(FRAME_BASE), .depth_base(DEPTH_BASE), .region_words(32'(NUM_WORDS)),
        .write_count(write_count), .stray_count(stray_count)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // bus rules seen from the memory side
    a_single_strobe: assert property (@(posedge CLK) disable iff (RESET) !(m_read && m_write))
        else begin
            protocol_errs++;
            $display("master raised read and write in the same cycle");
        end

    a_write_held: assert property (@(posedge CLK) disable iff (RESET)
        m_write && m_waitrequest |=> m_write && $stable(m_writedata))
        else begin
            protocol_errs++;
            $display("stalled write was dropped or changed its data");
        end

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatch_errs++;
            $display("Mismatch %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic reg_write(input logic [3:0] off, input logic [31:0] data);
        @(negedge CLK);
        chipselect = 1'b1;
        write      = 1'b1;
        address    = off;
        writedata  = data;
        @(negedge CLK);
        chipselect = 1'b0;
        write      = 1'b0;
    endtask

    task automatic reg_read(input logic [3:0] off, output logic [31:0] data);
        @(negedge CLK);
        chipselect = 1'b1;
        read       = 1'b1;
        address    = off;
        @(negedge CLK);
        data       = readdata;   // combinational, settled since the last edge
        chipselect = 1'b0;
        read       = 1'b0;
    endtask

    task automatic run_cmd(input string name, input gpu_pkg::mode_e mode);
        logic [31:0] done_word;
        int          polls;
        reg_write(gpu_pkg::REG_MODE, 32'(mode));
        reg_write(gpu_pkg::REG_START, 32'd1);
        done_word = '0;
        polls     = 0;
        while ((done_word[0] !== 1'b1) && (polls < CMD_TIMEOUT)) begin
            reg_read(gpu_pkg::REG_DONE, done_word);
            polls++;
        end
        assert (done_word[0] === 1'b1) else begin
            timeout_errs++;
            $display("%s: done was not set within %0d polls", name, CMD_TIMEOUT);
        end
        reg_write(gpu_pkg::REG_START, 32'd0);
        reg_write(gpu_pkg::REG_DONE, 32'd0);
    endtask

    function automatic logic [31:0] pixel_index(input logic [31:0] px, input logic [31:0] py);
        return (py >> gpu_pkg::FRAC_BITS) * 32'(SCREEN_W) + (px >> gpu_pkg::FRAC_BITS);
    endfunction

    task automatic check_buffer(input string name, input logic [31:0] base,
                                input logic [31:0] expected);
        for (int i = 0; i < NUM_WORDS; i++)
            check_word($sformatf("%s[%0d]", name, i), expected, i_mem.mem[(base >> 2) + 32'(i)]);
    endtask

    task automatic plot_pixel(input string name, input logic [31:0] px, input logic [31:0] py,
                              input logic [31:0] pz, input logic [31:0] pcolor,
                              input int exp_writes);
        int writes_before;
        reg_write(gpu_pkg::REG_X, px);
        reg_write(gpu_pkg::REG_Y, py);
        reg_write(gpu_pkg::REG_Z, pz);
        reg_write(gpu_pkg::REG_COLOR, pcolor);
        writes_before = write_count;
        run_cmd(name, gpu_pkg::MODE_PLOT);
        check_word({name, " writes"}, 32'(exp_writes), 32'(write_count - writes_before));
        if (exp_writes == 2) begin   // drawn, colour then depth
            check_word({name, " colour"}, pcolor,
                       i_mem.mem[(FRAME_BASE >> 2) + pixel_index(px, py)]);
            check_word({name, " depth"}, pz,
                       i_mem.mem[(DEPTH_BASE >> 2) + pixel_index(px, py)]);
        end
    endtask

    initial begin
        logic [31:0] rd;
        int          offs[7] = '{0, 3, 4, 5, 6, 7, 8};
        int          writes_before;
        RESET      = 1'b1;
        chipselect = 1'b0;
        read       = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        repeat (8) @(negedge CLK);
        RESET = 1'b0;

        // register file after reset and readback
        for (int i = 0; i <= 8; i++) begin
            reg_read(4'(i), rd);
            check_word($sformatf("reset_value[%0d]", i), 32'd0, rd);
        end
        foreach (offs[i]) begin
            reg_write(4'(offs[i]), 32'hC0DE_0000 | (32'(offs[i]) << 8) | 32'(i));
            reg_read(4'(offs[i]), rd);
            check_word($sformatf("readback[%0d]", offs[i]),
                       32'hC0DE_0000 | (32'(offs[i]) << 8) | 32'(i), rd);
        end
        reg_write(gpu_pkg::REG_FRAME_PTR, FRAME_BASE);
        reg_write(gpu_pkg::REG_DEPTH_PTR, DEPTH_BASE);

        // exactly one write per frame word
        writes_before = write_count;
        run_cmd("frame_clear", gpu_pkg::MODE_CLEAR_FRAME);
        check_word("frame_clear writes", 32'(NUM_WORDS), 32'(write_count - writes_before));
        check_buffer("frame_clear", FRAME_BASE, gpu_pkg::SKY_COLOR);
        check_word("frame_clear stray", 32'd0, 32'(stray_count));
        run_cmd("depth_clear", gpu_pkg::MODE_CLEAR_DEPTH);
        check_buffer("depth_clear", DEPTH_BASE, gpu_pkg::FAR_DEPTH);

        plot_pixel("visible", 32'h540, 32'h320, 32'h1000, 32'h0012_3456, 2);
        plot_pixel("behind", 32'h540, 32'h320, 32'h2000, 32'h00FF_0000, 0);
        check_word("behind colour", 32'h0012_3456, i_mem.mem[(FRAME_BASE >> 2) + 32'd53]);
        check_word("behind depth", 32'h1000, i_mem.mem[(DEPTH_BASE >> 2) + 32'd53]);
        plot_pixel("x_zero", 32'h0, 32'h200, 32'h10, 32'h0000_00FF, 0);
        plot_pixel("y_below", 32'h440, 32'h800, 32'h10, 32'h0000_00FF, 0);
        plot_pixel("key_colour", 32'h700, 32'h200, 32'h10, gpu_pkg::KEY_COLOR, 0);

        // no bus traffic, then a normal command must still run
        writes_before = write_count;
        run_cmd("mode_none", gpu_pkg::MODE_NONE);
        check_word("mode_none writes", 32'd0, 32'(write_count - writes_before));
        plot_pixel("after_none", 32'h980, 32'h610, 32'h500, 32'h00AB_CDEF, 2);
        check_word("final stray", 32'd0, 32'(stray_count));

        $display("errors: mismatch %0d, timeout %0d, protocol %0d",
                 mismatch_errs, timeout_errs, protocol_errs);
        if ((mismatch_errs + timeout_errs + protocol_errs) == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* verif/mem_model.sv */
// mem_model: Avalon-MM memory slave with random stalls, delayed responses and a stray write count
`timescale 1ns/1ns
module mem_model (
    input  logic        CLK,
    input  logic        RESET,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    output logic [31:0] readdata,
    output logic        readdatavalid,
    output logic        writeresponsevalid,
    input  logic [31:0] frame_base,
    input  logic [31:0] depth_base,
    input  logic [31:0] region_words,
    output int          write_count,
    output int          stray_count
);

    logic [31:0] mem [logic [31:0]];   // word addressed
    int          seed = 35;
    int          cycle;
    int          last_due;
    int          due_q[$];             // cycle in which each response is due
    logic        kind_q[$];            // 1 for a read
    logic [31:0] data_q[$];

    always @(posedge CLK) begin
        logic [31:0] word;
        logic        in_region;
        int          due;
        if (RESET) begin
            waitrequest        <= 1'b1;
            readdata           <= '0;
            readdatavalid      <= 1'b0;
            writeresponsevalid <= 1'b0;
            write_count        <= 0;
            stray_count        <= 0;
            cycle    = 0;
            last_due = 0;
            due_q.delete();
            kind_q.delete();
            data_q.delete();
        end else begin
            cycle = cycle + 1;
            readdatavalid      <= 1'b0;
            writeresponsevalid <= 1'b0;
            if ((read || write) && !waitrequest) begin
                word = address >> 2;
                due  = cycle + 1 + int'($unsigned($random(seed)) % 3);
                if (due <= last_due)
                    due = last_due + 1;   // responses stay in order
                last_due = due;
                due_q.push_back(due);
                kind_q.push_back(read);
                if (read) begin
                    data_q.push_back(mem.exists(word) ? mem[word] : ~address);
                end else begin
                    mem[word] = writedata;
                    data_q.push_back(32'd0);
                    write_count <= write_count + 1;
                    in_region = ((word - (frame_base >> 2)) < region_words)
                             || ((word - (depth_base >> 2)) < region_words);
                    if (!in_region)
                        stray_count <= stray_count + 1;
                end
            end
            if ((due_q.size() > 0) && (due_q[0] <= cycle)) begin
                if (kind_q[0]) begin
                    readdatavalid <= 1'b1;
                    readdata      <= data_q[0];
                end else begin
                    writeresponsevalid <= 1'b1;
                end
                due_q.delete(0);
                kind_q.delete(0);
                data_q.delete(0);
            end
            waitrequest <= (($unsigned($random(seed)) % 3) == 0);   // stall about a third
        end
    end

endmodule

/* source/gpu_core.sv */
// gpu_core: pixel engine top level joining the slave register file and the master engine
`timescale 1ns/1ns
module gpu_core #(
    parameter int SCREEN_W = 320,
    parameter int SCREEN_H = 240
) (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         chipselect,
    input  logic                         read,
    input  logic                         write,
    input  logic [3:0]                   address,
    input  logic [gpu_pkg::DATA_W-1:0]   writedata,
    output logic [gpu_pkg::DATA_W-1:0]   readdata,
    output logic [gpu_pkg::DATA_W-1:0]   m_address,
    output logic                         m_read,
    output logic                         m_write,
    output logic [gpu_pkg::DATA_W-1:0]   m_writedata,
    input  logic                         m_waitrequest,
    input  logic [gpu_pkg::DATA_W-1:0]   m_readdata,
    input  logic                         m_readdatavalid,
    input  logic                         m_writeresponsevalid
);

    logic                       start, done_set;
    gpu_pkg::mode_e             mode;
    logic [gpu_pkg::DATA_W-1:0] frame_ptr, depth_ptr;
    logic [gpu_pkg::DATA_W-1:0] color, x, y, z;

    gpu_regs i_gpu_regs (
        .CLK        (CLK),
        .RESET      (RESET),
        .chipselect (chipselect),
        .read       (read),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .readdata   (readdata),
        .start      (start),
        .mode       (mode),
        .frame_ptr  (frame_ptr),
        .depth_ptr  (depth_ptr),
        .color      (color),
        .x          (x),
        .y          (y),
        .z          (z),
        .done_set   (done_set)
    );

    gpu_engine #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) i_gpu_engine (
        .CLK                  (CLK),
        .RESET                (RESET),
        .start                (start),
        .mode                 (mode),
        .frame_ptr            (frame_ptr),
        .depth_ptr            (depth_ptr),
        .color                (color),
        .x                    (x),
        .y                    (y),
        .z                    (z),
        .done_set             (done_set),
        .m_address            (m_address),
        .m_read               (m_read),
        .m_write              (m_write),
        .m_writedata          (m_writedata),
        .m_waitrequest        (m_waitrequest),
        .m_readdata           (m_readdata),
        .m_readdatavalid      (m_readdatavalid),
        .m_writeresponsevalid (m_writeresponsevalid)
    );

endmodule

/* source/gpu_engine.sv */
// gpu_engine: command sequencer that runs a clear or a plot and shares the master port
`timescale 1ns/1ns
module gpu_engine #(
    parameter int SCREEN_W = 320,
    parameter int SCREEN_H = 240
) (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         start,
    input  gpu_pkg::mode_e               mode,
    input  logic [gpu_pkg::DATA_W-1:0]   frame_ptr,
    input  logic [gpu_pkg::DATA_W-1:0]   depth_ptr,
    input  logic [gpu_pkg::DATA_W-1:0]   color,
    input  logic [gpu_pkg::DATA_W-1:0]   x,
    input  logic [gpu_pkg::DATA_W-1:0]   y,
    input  logic [gpu_pkg::DATA_W-1:0]   z,
    output logic                         done_set,
    output logic [gpu_pkg::DATA_W-1:0]   m_address,
    output logic                         m_read,
    output logic                         m_write,
    output logic [gpu_pkg::DATA_W-1:0]   m_writedata,
    input  logic                         m_waitrequest,
    input  logic [gpu_pkg::DATA_W-1:0]   m_readdata,
    input  logic                         m_readdatavalid,
    input  logic                         m_writeresponsevalid
);

    gpu_pkg::seq_state_e        state;
    logic                       launch;
    logic                       is_plot;
    logic                       clear_go, plot_go;
    logic                       clear_finish, plot_finish, sub_finish;
    logic [gpu_pkg::DATA_W-1:0] clear_base, clear_word;
    logic [gpu_pkg::DATA_W-1:0] clear_addr, clear_data;
    logic                       clear_write;
    logic [gpu_pkg::DATA_W-1:0] plot_addr, plot_data;
    logic                       plot_read, plot_write;

    assign is_plot  = (mode == gpu_pkg::MODE_PLOT);
    assign launch   = (state == gpu_pkg::SEQ_IDLE) && start && (mode != gpu_pkg::MODE_NONE);
    assign clear_go = launch && !is_plot;
    assign plot_go  = launch && is_plot;

    assign sub_finish = is_plot ? plot_finish : clear_finish;
    // pulse on the step into SEQ_DONE
    assign done_set = ((state == gpu_pkg::SEQ_RUNNING) && sub_finish)
                   || ((state == gpu_pkg::SEQ_IDLE) && start && (mode == gpu_pkg::MODE_NONE));

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= gpu_pkg::SEQ_IDLE;
        end else begin
            case (state)
                gpu_pkg::SEQ_IDLE:
                    if (start)
                        state <= (mode == gpu_pkg::MODE_NONE) ? gpu_pkg::SEQ_DONE
                                                               : gpu_pkg::SEQ_RUNNING;
                gpu_pkg::SEQ_RUNNING:
                    if (sub_finish)
                        state <= gpu_pkg::SEQ_DONE;
                gpu_pkg::SEQ_DONE:
                    if (!start)
                        state <= gpu_pkg::SEQ_IDLE;   // wait for software to drop start
                default:
                    state <= gpu_pkg::SEQ_IDLE;
            endcase
        end
    end

    // frame clear paints sky, depth clear sets the far plane
    assign clear_base = (mode == gpu_pkg::MODE_CLEAR_FRAME) ? frame_ptr : depth_ptr;
    assign clear_word = (mode == gpu_pkg::MODE_CLEAR_FRAME) ? gpu_pkg::SKY_COLOR
                                                             : gpu_pkg::FAR_DEPTH;

    buffer_clear #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) i_buffer_clear (
        .CLK           (CLK),
        .RESET         (RESET),
        .go            (clear_go),
        .base          (clear_base),
        .fill_word     (clear_word),
        .m_waitrequest (m_waitrequest),
        .m_address     (clear_addr),
        .m_write       (clear_write),
        .m_writedata   (clear_data),
        .finish        (clear_finish)
    );

    pixel_plot #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) i_pixel_plot (
        .CLK                  (CLK),
        .RESET                (RESET),
        .go                   (plot_go),
        .frame_ptr            (frame_ptr),
        .depth_ptr            (depth_ptr),
        .color                (color),
        .x                    (x),
        .y                    (y),
        .z                    (z),
        .m_waitrequest        (m_waitrequest),
        .m_readdata           (m_readdata),
        .m_readdatavalid      (m_readdatavalid),
        .m_writeresponsevalid (m_writeresponsevalid),
        .m_address            (plot_addr),
        .m_read               (plot_read),
        .m_write              (plot_write),
        .m_writedata          (plot_data),
        .finish               (plot_finish)
    );

    always_comb begin
        m_address   = is_plot ? plot_addr : clear_addr;
        m_writedata = is_plot ? plot_data : clear_data;
        m_read      = 1'b0;
        m_write     = 1'b0;
        if (state == gpu_pkg::SEQ_RUNNING) begin   // bus quiet outside a command
            m_read  = is_plot && plot_read;
            m_write = is_plot ? plot_write : clear_write;
        end
    end

    // a sub-engine only finishes inside a running command
    a_finish_in_run: assert property (
        @(posedge CLK) disable iff (RESET)
        (clear_finish || plot_finish) |-> (state == gpu_pkg::SEQ_RUNNING)
    );

endmodule

/* source/pixel_plot.sv */
// pixel_plot: depth tested write of one pixel, read depth then write colour and depth
`timescale 1ns/1ns
module pixel_plot #(
    parameter int SCREEN_W = 320,
    parameter int SCREEN_H = 240
) (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         go,
    input  logic [gpu_pkg::DATA_W-1:0]   frame_ptr,
    input  logic [gpu_pkg::DATA_W-1:0]   depth_ptr,
    input  logic [gpu_pkg::DATA_W-1:0]   color,
    input  logic [gpu_pkg::DATA_W-1:0]   x,
    input  logic [gpu_pkg::DATA_W-1:0]   y,
    input  logic [gpu_pkg::DATA_W-1:0]   z,
    input  logic                         m_waitrequest,
    input  logic [gpu_pkg::DATA_W-1:0]   m_readdata,
    input  logic                         m_readdatavalid,
    input  logic                         m_writeresponsevalid,
    output logic [gpu_pkg::DATA_W-1:0]   m_address,
    output logic                         m_read,
    output logic                         m_write,
    output logic [gpu_pkg::DATA_W-1:0]   m_writedata,
    output logic                         finish
);

    gpu_pkg::plot_state_e       state;
    logic                       issued;   // command accepted, response pending
    logic                       resp;
    logic                       on_screen, draw;
    logic [gpu_pkg::DATA_W-1:0] pix_off;

    // byte offset of the pixel within either buffer
    assign pix_off = (((y >> gpu_pkg::FRAC_BITS) * SCREEN_W)
                    + (x >> gpu_pkg::FRAC_BITS)) << 2;

    assign on_screen = ($signed(x) > 0) && ($signed(x) < (SCREEN_W << gpu_pkg::FRAC_BITS))
                    && ($signed(y) > 0) && ($signed(y) < (SCREEN_H << gpu_pkg::FRAC_BITS));

    assign draw = on_screen && ($signed(m_readdata) > $signed(z))
               && (color[23:0] != gpu_pkg::KEY_COLOR[23:0]);

    assign resp = issued && ((state == gpu_pkg::PLOT_Z_READ) ? m_readdatavalid
                                                             : m_writeresponsevalid);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state  <= gpu_pkg::PLOT_IDLE;
            issued <= 1'b0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if ((m_read || m_write) && !m_waitrequest)
                issued <= 1'b1;
            else if (resp)
                issued <= 1'b0;
            case (state)
                gpu_pkg::PLOT_IDLE:
                    if (go)
                        state <= gpu_pkg::PLOT_Z_READ;
                gpu_pkg::PLOT_Z_READ:
                    if (resp) begin
                        if (draw) begin
                            state <= gpu_pkg::PLOT_RGB_WRITE;
                        end else begin
                            state  <= gpu_pkg::PLOT_IDLE;   // hidden, off screen or keyed
                            finish <= 1'b1;
                        end
                    end
                gpu_pkg::PLOT_RGB_WRITE:
                    if (resp)
                        state <= gpu_pkg::PLOT_Z_WRITE;
                default:
                    if (resp) begin
                        state  <= gpu_pkg::PLOT_IDLE;
                        finish <= 1'b1;
                    end
            endcase
        end
    end

    assign m_read  = (state == gpu_pkg::PLOT_Z_READ) && !issued;
    assign m_write = ((state == gpu_pkg::PLOT_RGB_WRITE) || (state == gpu_pkg::PLOT_Z_WRITE))
                  && !issued;
    assign m_writedata = (state == gpu_pkg::PLOT_RGB_WRITE) ? color : z;

    always_comb begin
        case (state)
            gpu_pkg::PLOT_Z_READ:    m_address = on_screen ? depth_ptr + pix_off : depth_ptr;
            gpu_pkg::PLOT_RGB_WRITE: m_address = frame_ptr + pix_off;
            default:                 m_address = depth_ptr + pix_off;
        endcase
    end

    // a stalled command holds still until it is accepted
    a_hold_on_wait: assert property (
        @(posedge CLK) disable iff (RESET)
        (m_read || m_write) && m_waitrequest
            |=> $stable(m_address) && $stable(m_read) && $stable(m_write)
    );

endmodule

/* source/buffer_clear.sv */
// buffer_clear: writes one fill word to every pixel of a buffer over the master port
`timescale 1ns/1ns
module buffer_clear #(
    parameter int SCREEN_W = 320,
    parameter int SCREEN_H = 240
) (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         go,
    input  logic [gpu_pkg::DATA_W-1:0]   base,
    input  logic [gpu_pkg::DATA_W-1:0]   fill_word,
    input  logic                         m_waitrequest,
    output logic [gpu_pkg::DATA_W-1:0]   m_address,
    output logic                         m_write,
    output logic [gpu_pkg::DATA_W-1:0]   m_writedata,
    output logic                         finish
);

    localparam int NUM_WORDS = SCREEN_W * SCREEN_H;
    localparam int CNT_W     = $clog2(NUM_WORDS + 1);

    logic [CNT_W-1:0] count;   // accepted writes so far
    logic             active;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active <= 1'b0;
            count  <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (go) begin
                active <= 1'b1;
                count  <= '0;
            end else if (active && !m_waitrequest) begin
                count <= count + 1'b1;
                if (count == CNT_W'(NUM_WORDS - 1)) begin
                    active <= 1'b0;
                    finish <= 1'b1;   // one cycle after the last acceptance
                end
            end
        end
    end

    // writes are posted, responses are not tracked
    assign m_write     = active;
    assign m_writedata = fill_word;
    assign m_address   = base + (gpu_pkg::DATA_W'(count) << 2);

    a_count_range: assert property (
        @(posedge CLK) disable iff (RESET) count <= CNT_W'(NUM_WORDS)
    );

endmodule

/* source/gpu_regs.sv */
// gpu_regs: Avalon-MM slave register file holding the command, pointers and pixel values
`timescale 1ns/1ns
module gpu_regs (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         chipselect,
    input  logic                         read,
    input  logic                         write,
    input  logic [3:0]                   address,
    input  logic [gpu_pkg::DATA_W-1:0]   writedata,
    output logic [gpu_pkg::DATA_W-1:0]   readdata,
    output logic                         start,
    output gpu_pkg::mode_e               mode,
    output logic [gpu_pkg::DATA_W-1:0]   frame_ptr,
    output logic [gpu_pkg::DATA_W-1:0]   depth_ptr,
    output logic [gpu_pkg::DATA_W-1:0]   color,
    output logic [gpu_pkg::DATA_W-1:0]   x,
    output logic [gpu_pkg::DATA_W-1:0]   y,
    output logic [gpu_pkg::DATA_W-1:0]   z,
    input  logic                         done_set
);

    logic                       done;
    logic [gpu_pkg::DATA_W-1:0] mode_word;   // full word kept for readback
    gpu_pkg::reg_addr_e         reg_sel;

    assign reg_sel = gpu_pkg::reg_addr_e'(address);
    assign mode    = gpu_pkg::mode_e'(mode_word[1:0]);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            frame_ptr <= '0;
            depth_ptr <= '0;
            color     <= '0;
            x         <= '0;
            y         <= '0;
            z         <= '0;
            mode_word <= '0;
            start     <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (chipselect && write) begin
                case (reg_sel)
                    gpu_pkg::REG_FRAME_PTR: frame_ptr <= writedata;
                    gpu_pkg::REG_START:     start     <= writedata[0];
                    gpu_pkg::REG_DONE:      done      <= writedata[0];
                    gpu_pkg::REG_DEPTH_PTR: depth_ptr <= writedata;
                    gpu_pkg::REG_COLOR:     color     <= writedata;
                    gpu_pkg::REG_X:         x         <= writedata;
                    gpu_pkg::REG_Y:         y         <= writedata;
                    gpu_pkg::REG_Z:         z         <= writedata;
                    gpu_pkg::REG_MODE:      mode_word <= writedata;
                    default: ;
                endcase
            end
            if (done_set)
                done <= 1'b1;   // engine wins over a host write
        end
    end

    // read data is valid in the same cycle
    always_comb begin
        readdata = '0;
        if (chipselect && read) begin
            case (reg_sel)
                gpu_pkg::REG_FRAME_PTR: readdata = frame_ptr;
                gpu_pkg::REG_START:     readdata[0] = start;
                gpu_pkg::REG_DONE:      readdata[0] = done;
                gpu_pkg::REG_DEPTH_PTR: readdata = depth_ptr;
                gpu_pkg::REG_COLOR:     readdata = color;
                gpu_pkg::REG_X:         readdata = x;
                gpu_pkg::REG_Y:         readdata = y;
                gpu_pkg::REG_Z:         readdata = z;
                gpu_pkg::REG_MODE:      readdata = mode_word;
                default:                readdata = '0;
            endcase
        end
    end

    // the engine only finishes a command that software has started
    a_done_needs_start: assert property (
        @(posedge CLK) disable iff (RESET) done_set |-> start
    );

endmodule

/* source/gpu_pkg.sv */
// gpu_pkg: register map, state and mode encodings and constants for the pixel engine
package gpu_pkg;

    localparam int DATA_W    = 32;
    localparam int FRAC_BITS = 8;   // fixed point fraction of x, y and z

    // word offsets of the slave register map
    typedef enum logic [3:0] {
        REG_FRAME_PTR = 4'd0,
        REG_START     = 4'd1,
        REG_DONE      = 4'd2,
        REG_DEPTH_PTR = 4'd3,
        REG_COLOR     = 4'd4,
        REG_X         = 4'd5,
        REG_Y         = 4'd6,
        REG_Z         = 4'd7,
        REG_MODE      = 4'd8
    } reg_addr_e;

    typedef enum logic [1:0] {
        MODE_NONE        = 2'd0,
        MODE_PLOT        = 2'd1,
        MODE_CLEAR_FRAME = 2'd2,
        MODE_CLEAR_DEPTH = 2'd3
    } mode_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUNNING,
        SEQ_DONE
    } seq_state_e;

    typedef enum logic [1:0] {
        PLOT_IDLE,
        PLOT_Z_READ,
        PLOT_RGB_WRITE,
        PLOT_Z_WRITE
    } plot_state_e;

    localparam logic [DATA_W-1:0] SKY_COLOR = 32'h0087CEEB;
    localparam logic [DATA_W-1:0] FAR_DEPTH = 32'h7FFFFFFF;   // largest positive depth
    localparam logic [DATA_W-1:0] KEY_COLOR = 32'h00FFFF00;   // transparent yellow

endpackage
